//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Physical address
    localparam int paddr_w = 15;

    // Bits below the set index (byte within the line)
    localparam int offset_w = 5;

    // Associativity
    localparam int ways = 4;

    // Line data, and the bit mask for masked writes
    localparam int line_w = 128;

    // Pending transaction ID from the MSHR
    localparam int id_w = 7;

    // LRU age per way, 0 is most recent
    localparam int age_w = 2;

endpackage

`default_nettype wire

//--- design/cache_stage1.sv
`timescale 1ns/100ps
`default_nettype none

module cache_stage1 #(
    parameter int sets = 4
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          valid_in,
    input  logic                          r,
    input  logic                          w,
    input  logic                          from_bus,
    input  logic                          pcd_in,
    input  logic [cache_pkg::paddr_w-1:0] paddr_in,
    input  logic [cache_pkg::id_w-1:0]    ptc_id_in,
    input  logic [cache_pkg::line_w-1:0]  data_in,
    input  logic [cache_pkg::line_w-1:0]  mask_in,

    // From MSHR and serializers
    input  logic                          mshr_full,
    input  logic                          ser0_full,
    input  logic                          ser1_full,

    output logic                          hit,
    output logic                          miss,
    output logic                          stall,
    output logic                          ex_clr,
    output logic                          ex_wb,
    output logic [cache_pkg::paddr_w-1:0] ext_address,

    output logic                          valid_out,
    output logic                          read,
    output logic [cache_pkg::line_w-1:0]  cache_line
);

    localparam int idx_w = $clog2(sets);
    localparam int tag_w = cache_pkg::paddr_w - cache_pkg::offset_w - idx_w;

    logic [idx_w-1:0] index;
    logic [tag_w-1:0] tag;
    logic [tag_w-1:0] victim_tag;

    logic [cache_pkg::ways-1:0] tag_match;
    logic [cache_pkg::ways-1:0] hit_vec;
    logic [cache_pkg::ways-1:0] fill_vec;
    logic [cache_pkg::ways-1:0] valid_bits;
    logic [cache_pkg::ways-1:0] dirty_bits;
    logic [cache_pkg::ways-1:0] lock_bits;
    logic [cache_pkg::ways-1:0] victim_way;
    logic [cache_pkg::ways-1:0] data_way;
    logic [cache_pkg::ways*cache_pkg::age_w-1:0] ages;

    logic victim_dirty;
    logic all_locked;
    logic lookup;
    logic fill;
    logic alloc_we;
    logic write_hit;
    logic stall_cond;

    assign index = paddr_in[cache_pkg::offset_w +: idx_w];
    assign tag   = paddr_in[cache_pkg::paddr_w-1 -: tag_w];

    // Fills come from the bus, everything else is a lookup
    assign lookup = valid_in & ~from_bus;
    assign fill   = valid_in & from_bus;

    assign hit_vec  = tag_match & valid_bits;
    assign fill_vec = tag_match & lock_bits;

    assign hit  = lookup & ~pcd_in & (|hit_vec);
    assign miss = lookup & ~hit;

    // ser1 takes every miss, ser0 only the victim writeback
    assign stall_cond = mshr_full | ser1_full | all_locked |
                        (ser0_full & victim_dirty & ~pcd_in);
    assign stall  = miss & stall_cond;
    assign ex_clr = miss & ~stall;
    assign ex_wb  = ex_clr & ~pcd_in & victim_dirty;

    assign ext_address = {victim_tag, index, {cache_pkg::offset_w{1'b0}}};

    // Uncached misses skip allocation
    assign alloc_we  = ex_clr & ~pcd_in;
    assign write_hit = hit & w;
    assign data_way  = fill ? fill_vec : hit_vec;

    tag_store #(
        .sets(sets)
    ) u_tags (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .tag_in     (tag),
        .tag_we     (alloc_we),
        .tag_way    (victim_way),
        .victim_way (victim_way),
        .tag_match  (tag_match),
        .victim_tag (victim_tag)
    );

    meta_store #(
        .sets(sets)
    ) u_meta (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .hit_we     (hit),
        .hit_way    (hit_vec),
        .write_hit  (write_hit),
        .alloc_we   (alloc_we),
        .alloc_way  (victim_way),
        .alloc_id   (ptc_id_in),
        .fill_we    (fill),
        .fill_way   (fill_vec),
        .valid_bits (valid_bits),
        .dirty_bits (dirty_bits),
        .lock_bits  (lock_bits),
        .ages       (ages),
        .pending_id ()
    );

    way_select u_victim (
        .valid_bits   (valid_bits),
        .dirty_bits   (dirty_bits),
        .lock_bits    (lock_bits),
        .ages         (ages),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .all_locked   (all_locked)
    );

    data_store #(
        .sets(sets)
    ) u_data (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .way        (data_way),
        .write_en   (write_hit),
        .fill_en    (fill),
        .data_in    (data_in),
        .mask_in    (mask_in),
        .read_en    (hit | fill),
        .cache_line (cache_line)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
            read      <= 1'b0;
        end else begin
            valid_out <= valid_in & ~stall;
            read      <= hit & r;
        end
    end

endmodule

`default_nettype wire

//--- design/data_store.sv
`timescale 1ns/100ps
`default_nettype none

module data_store #(
    parameter int sets = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [$clog2(sets)-1:0]      index,
    input  logic [cache_pkg::ways-1:0]   way,
    input  logic                         write_en,
    input  logic                         fill_en,
    input  logic [cache_pkg::line_w-1:0] data_in,
    input  logic [cache_pkg::line_w-1:0] mask_in,
    input  logic                         read_en,
    output logic [cache_pkg::line_w-1:0] cache_line
);

    logic [cache_pkg::line_w-1:0] lines [sets][cache_pkg::ways];
    logic [cache_pkg::line_w-1:0] cur_line;
    logic [cache_pkg::line_w-1:0] next_line;

    always_comb begin
        cur_line = '0;
        for (int i = 0; i < cache_pkg::ways; i++) begin
            if (way[i]) begin
                cur_line = lines[index][i];
            end
        end
    end

    // Masked merge for a write, whole line for a fill
    always_comb begin
        if (write_en) begin
            next_line = (cur_line & ~mask_in) | (data_in & mask_in);
        end else if (fill_en) begin
            next_line = data_in;
        end else begin
            next_line = cur_line;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en || fill_en) begin
            for (int i = 0; i < cache_pkg::ways; i++) begin
                if (way[i]) begin
                    lines[index][i] <= next_line;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !read_en) begin
            cache_line <= '0;
        end else begin
            cache_line <= next_line;
        end
    end

endmodule

`default_nettype wire

//--- design/meta_store.sv
`timescale 1ns/100ps
`default_nettype none

module meta_store #(
    parameter int sets = 4
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [$clog2(sets)-1:0]                       index,
    input  logic                                          hit_we,
    input  logic [cache_pkg::ways-1:0]                    hit_way,
    input  logic                                          write_hit,
    input  logic                                          alloc_we,
    input  logic [cache_pkg::ways-1:0]                    alloc_way,
    input  logic [cache_pkg::id_w-1:0]                    alloc_id,
    input  logic                                          fill_we,
    input  logic [cache_pkg::ways-1:0]                    fill_way,
    output logic [cache_pkg::ways-1:0]                    valid_bits,
    output logic [cache_pkg::ways-1:0]                    dirty_bits,
    output logic [cache_pkg::ways-1:0]                    lock_bits,
    output logic [cache_pkg::ways*cache_pkg::age_w-1:0]   ages,
    output logic [cache_pkg::id_w-1:0]                    pending_id
);

    logic [cache_pkg::ways-1:0]  valid_q [sets];
    logic [cache_pkg::ways-1:0]  dirty_q [sets];
    logic [cache_pkg::ways-1:0]  lock_q [sets];
    logic [cache_pkg::id_w-1:0]  pid_q [sets][cache_pkg::ways];
    logic [cache_pkg::age_w-1:0] age_q [sets][cache_pkg::ways];

    logic [cache_pkg::age_w-1:0]          hit_age;
    logic [(1 << cache_pkg::age_w)-1:0]   age_seen;

    assign valid_bits = valid_q[index];
    assign dirty_bits = dirty_q[index];
    assign lock_bits  = lock_q[index];

    always_comb begin
        hit_age    = '0;
        pending_id = '0;
        age_seen   = '0;
        for (int i = 0; i < cache_pkg::ways; i++) begin
            ages[i*cache_pkg::age_w +: cache_pkg::age_w] = age_q[index][i];
            age_seen[age_q[index][i]] = 1'b1;
            if (hit_way[i]) begin
                hit_age = age_q[index][i];
            end
            if (fill_way[i]) begin
                pending_id = pid_q[index][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lock_q[s]  <= '0;
                // Way n starts at age n
                for (int i = 0; i < cache_pkg::ways; i++) begin
                    age_q[s][i] <= i[cache_pkg::age_w-1:0];
                end
            end
        end else begin
            if (hit_we) begin
                for (int i = 0; i < cache_pkg::ways; i++) begin
                    if (hit_way[i]) begin
                        age_q[index][i] <= '0;
                    end else if (age_q[index][i] < hit_age) begin
                        age_q[index][i] <= age_q[index][i] + 1'b1;
                    end
                end
                if (write_hit) begin
                    dirty_q[index] <= dirty_q[index] | hit_way;
                end
            end
            // Allocation locks the way until its fill returns
            if (alloc_we) begin
                valid_q[index] <= valid_q[index] & ~alloc_way;
                dirty_q[index] <= dirty_q[index] & ~alloc_way;
                lock_q[index]  <= lock_q[index] | alloc_way;
                for (int i = 0; i < cache_pkg::ways; i++) begin
                    if (alloc_way[i]) begin
                        pid_q[index][i] <= alloc_id;
                    end
                end
            end
            if (fill_we) begin
                valid_q[index] <= valid_q[index] | fill_way;
                dirty_q[index] <= dirty_q[index] & ~fill_way;
                lock_q[index]  <= lock_q[index] & ~fill_way;
            end
        end
    end

    // Ages of the addressed set stay a permutation
    age_perm_a: assert property (
        @(posedge clk) disable iff (rst) &age_seen
    );

    // A returning fill must land on a way allocated by an earlier miss
    fill_locked_a: assert property (
        @(posedge clk) disable iff (rst) fill_we |-> |(fill_way & lock_q[index])
    );

endmodule

`default_nettype wire

//--- design/tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module tag_store #(
    parameter int sets = 4
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [$clog2(sets)-1:0]                  index,
    input  logic [cache_pkg::paddr_w-cache_pkg::offset_w-$clog2(sets)-1:0] tag_in,
    input  logic                                     tag_we,
    input  logic [cache_pkg::ways-1:0]               tag_way,
    input  logic [cache_pkg::ways-1:0]               victim_way,
    output logic [cache_pkg::ways-1:0]               tag_match,
    output logic [cache_pkg::paddr_w-cache_pkg::offset_w-$clog2(sets)-1:0] victim_tag
);

    localparam int idx_w = $clog2(sets);
    localparam int tag_w = cache_pkg::paddr_w - cache_pkg::offset_w - idx_w;

    logic [tag_w-1:0] tags [sets][cache_pkg::ways];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                for (int i = 0; i < cache_pkg::ways; i++) begin
                    tags[s][i] <= '0;
                end
            end
        end else if (tag_we) begin
            for (int i = 0; i < cache_pkg::ways; i++) begin
                if (tag_way[i]) begin
                    tags[index][i] <= tag_in;
                end
            end
        end
    end

    // Parallel compare over the set, plus old tag of the victim
    always_comb begin
        victim_tag = '0;
        for (int i = 0; i < cache_pkg::ways; i++) begin
            tag_match[i] = (tags[index][i] == tag_in);
            if (victim_way[i]) begin
                victim_tag = tags[index][i];
            end
        end
    end

    // Victim choice upstream must give exactly one way to allocate
    tag_way_onehot_a: assert property (
        @(posedge clk) disable iff (rst) tag_we |-> $onehot(tag_way)
    );

endmodule

`default_nettype wire

//--- design/way_select.sv
`timescale 1ns/100ps
`default_nettype none

module way_select (
    input  logic [cache_pkg::ways-1:0]                  valid_bits,
    input  logic [cache_pkg::ways-1:0]                  dirty_bits,
    input  logic [cache_pkg::ways-1:0]                  lock_bits,
    input  logic [cache_pkg::ways*cache_pkg::age_w-1:0] ages,
    output logic [cache_pkg::ways-1:0]                  victim_way,
    output logic                                        victim_dirty,
    output logic                                        all_locked
);

    logic [cache_pkg::ways-1:0]  free_ways;
    logic [cache_pkg::age_w-1:0] best_age;
    logic                        found;

    assign free_ways  = ~valid_bits & ~lock_bits;
    assign all_locked = &lock_bits;

    always_comb begin
        victim_way = '0;
        best_age   = '0;
        found      = 1'b0;

        // Lowest free way first
        for (int i = 0; i < cache_pkg::ways; i++) begin
            if (free_ways[i] && !found) begin
                victim_way[i] = 1'b1;
                found         = 1'b1;
            end
        end

        // Otherwise oldest unlocked way
        if (!found) begin
            for (int i = 0; i < cache_pkg::ways; i++) begin
                if (!lock_bits[i] &&
                    (!found || ages[i*cache_pkg::age_w +: cache_pkg::age_w] > best_age)) begin
                    victim_way    = '0;
                    victim_way[i] = 1'b1;
                    best_age      = ages[i*cache_pkg::age_w +: cache_pkg::age_w];
                    found         = 1'b1;
                end
            end
        end
    end

    // Writeback needed only for a valid dirty victim
    assign victim_dirty = |(victim_way & valid_bits & dirty_bits);

endmodule

`default_nettype wire

//--- files.f
+incdir+testbench
design/cache_pkg.sv
design/tag_store.sv
design/meta_store.sv
design/way_select.sv
design/data_store.sv
design/cache_stage1.sv
testbench/cache_stage1_tb.sv

//--- testbench/cache_vectors.svh
`ifndef CACHE_VECTORS_SVH
`define CACHE_VECTORS_SVH

// Columns: op, paddr, ptc id, random data, {mshr_full, ser0_full, ser1_full},
// expected {hit, miss, stall, ex_clr, ex_wb, valid_out, read}, ext_address
typedef struct packed {
    logic [2:0]  op;
    logic [14:0] addr;
    logic [6:0]  id;
    logic        rnd;
    logic [2:0]  bp;
    logic [6:0]  exp;
    logic [14:0] ext;
} vec_t;

localparam logic [2:0] op_rd   = 3'd1;
localparam logic [2:0] op_wr   = 3'd2;
localparam logic [2:0] op_fill = 3'd3;
localparam logic [2:0] op_ucrd = 3'd4;

localparam int num_vectors = 26;

vec_t vectors [num_vectors];

task automatic load_vectors;
    // Cold misses fill ways 0 to 3 of set 0, then the set is fully pending
    vectors[0]  = '{op_rd,   15'h0080, 7'd1, 1'b0, 3'b000, 7'b01010_10, 15'h0000};
    vectors[1]  = '{op_rd,   15'h0100, 7'd2, 1'b0, 3'b000, 7'b01010_10, 15'h0000};
    vectors[2]  = '{op_rd,   15'h0180, 7'd3, 1'b0, 3'b000, 7'b01010_10, 15'h0000};
    vectors[3]  = '{op_rd,   15'h0200, 7'd4, 1'b0, 3'b000, 7'b01010_10, 15'h0000};
    vectors[4]  = '{op_rd,   15'h0280, 7'd5, 1'b0, 3'b000, 7'b01100_00, 15'h0000};
    // Bus fills
    vectors[5]  = '{op_fill, 15'h0080, 7'd0, 1'b0, 3'b000, 7'b00000_10, 15'h0000};
    vectors[6]  = '{op_fill, 15'h0100, 7'd0, 1'b0, 3'b000, 7'b00000_10, 15'h0000};
    vectors[7]  = '{op_fill, 15'h0180, 7'd0, 1'b0, 3'b000, 7'b00000_10, 15'h0000};
    vectors[8]  = '{op_fill, 15'h0200, 7'd0, 1'b0, 3'b000, 7'b00000_10, 15'h0000};
    // Uncached probe reports the fourth tag in way 3 as victim
    vectors[9]  = '{op_ucrd, 15'h0080, 7'd0, 1'b0, 3'b000, 7'b01010_10, 15'h0200};
    // Read hits, ages end as 3 2 1 0
    vectors[10] = '{op_rd,   15'h0080, 7'd0, 1'b0, 3'b000, 7'b10000_11, 15'h0000};
    vectors[11] = '{op_rd,   15'h0100, 7'd0, 1'b0, 3'b000, 7'b10000_11, 15'h0000};
    vectors[12] = '{op_rd,   15'h0180, 7'd0, 1'b0, 3'b000, 7'b10000_11, 15'h0000};
    vectors[13] = '{op_rd,   15'h0200, 7'd0, 1'b0, 3'b000, 7'b10000_11, 15'h0000};
    // Dirty way 1, then touching 0, 2, 3 leaves way 1 oldest
    vectors[14] = '{op_wr,   15'h0100, 7'd0, 1'b1, 3'b000, 7'b10000_10, 15'h0000};
    vectors[15] = '{op_rd,   15'h0080, 7'd0, 1'b0, 3'b000, 7'b10000_11, 15'h0000};
    vectors[16] = '{op_rd,   15'h0180, 7'd0, 1'b0, 3'b000, 7'b10000_11, 15'h0000};
    vectors[17] = '{op_rd,   15'h0200, 7'd0, 1'b0, 3'b000, 7'b10000_11, 15'h0000};
    // Uncached read of a cached line while dirty way 1 is the victim
    vectors[18] = '{op_ucrd, 15'h0080, 7'd7, 1'b0, 3'b000, 7'b01010_10, 15'h0100};
    // Back-pressure on the evicting miss, then the held request goes through
    vectors[19] = '{op_rd,   15'h0280, 7'd6, 1'b0, 3'b100, 7'b01100_00, 15'h0000};
    vectors[20] = '{op_rd,   15'h0280, 7'd6, 1'b0, 3'b010, 7'b01100_00, 15'h0000};
    vectors[21] = '{op_rd,   15'h0280, 7'd6, 1'b0, 3'b001, 7'b01100_00, 15'h0000};
    vectors[22] = '{op_rd,   15'h0280, 7'd6, 1'b0, 3'b000, 7'b01011_10, 15'h0100};
    // Uncached line still hits and the pending fill returns
    vectors[23] = '{op_rd,   15'h0080, 7'd0, 1'b0, 3'b000, 7'b10000_11, 15'h0000};
    vectors[24] = '{op_fill, 15'h0280, 7'd0, 1'b0, 3'b000, 7'b00000_10, 15'h0000};
    vectors[25] = '{op_rd,   15'h0280, 7'd0, 1'b0, 3'b000, 7'b10000_11, 15'h0000};
endtask

`endif

//--- testbench/cache_stage1_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cache_stage1_tb;

    localparam int sets = 4;

    logic                          clk;
    logic                          rst;
    logic                          valid_in;
    logic                          r;
    logic                          w;
    logic                          from_bus;
    logic                          pcd_in;
    logic [cache_pkg::paddr_w-1:0] paddr_in;
    logic [cache_pkg::id_w-1:0]    ptc_id_in;
    logic [cache_pkg::line_w-1:0]  data_in;
    logic [cache_pkg::line_w-1:0]  mask_in;
    logic                          mshr_full;
    logic                          ser0_full;
    logic                          ser1_full;
    logic                          hit;
    logic                          miss;
    logic                          stall;
    logic                          ex_clr;
    logic                          ex_wb;
    logic [cache_pkg::paddr_w-1:0] ext_address;
    logic                          valid_out;
    logic                          read;
    logic [cache_pkg::line_w-1:0]  cache_line;

    `include "cache_vectors.svh"

    // Expected line contents, keyed by line address
    logic [cache_pkg::line_w-1:0] model [int];

    logic                         exp_vo;
    logic                         exp_rd;
    logic [cache_pkg::line_w-1:0] exp_line;

    cache_stage1 #(
        .sets(sets)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .valid_in    (valid_in),
        .r           (r),
        .w           (w),
        .from_bus    (from_bus),
        .pcd_in      (pcd_in),
        .paddr_in    (paddr_in),
        .ptc_id_in   (ptc_id_in),
        .data_in     (data_in),
        .mask_in     (mask_in),
        .mshr_full   (mshr_full),
        .ser0_full   (ser0_full),
        .ser1_full   (ser1_full),
        .hit         (hit),
        .miss        (miss),
        .stall       (stall),
        .ex_clr      (ex_clr),
        .ex_wb       (ex_wb),
        .ext_address (ext_address),
        .valid_out   (valid_out),
        .read        (read),
        .cache_line  (cache_line)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Bus data for a fill, built from the full address
    function automatic logic [cache_pkg::line_w-1:0] line_pattern(input logic [14:0] addr);
        return {8{addr, 1'b1}};
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("ERROR: time %0t signal %s actual %h expected %h",
                     $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_row(input vec_t v);
        valid_in  = 1'b1;
        r         = (v.op == op_rd) || (v.op == op_ucrd);
        w         = (v.op == op_wr);
        from_bus  = (v.op == op_fill);
        pcd_in    = (v.op == op_ucrd);
        paddr_in  = v.addr;
        ptc_id_in = v.id;
        mshr_full = v.bp[2];
        ser0_full = v.bp[1];
        ser1_full = v.bp[0];
        if (v.rnd) begin
            data_in = {$urandom, $urandom, $urandom, $urandom};
            mask_in = {$urandom, $urandom, $urandom, $urandom};
        end else if (v.op == op_fill) begin
            data_in = line_pattern(v.addr);
            mask_in = '0;
        end else begin
            data_in = '0;
            mask_in = '0;
        end
    endtask

    task automatic check_lookup(input vec_t v);
        check_value("hit", hit, v.exp[6]);
        check_value("miss", miss, v.exp[5]);
        check_value("stall", stall, v.exp[4]);
        check_value("ex_clr", ex_clr, v.exp[3]);
        check_value("ex_wb", ex_wb, v.exp[2]);
        if (v.exp[3]) begin
            check_value("ext_address", ext_address, v.ext);
        end
    endtask

    // Next-cycle line from the fill and masked-merge rules
    task automatic predict_line(input vec_t v);
        int key;
        key = int'(v.addr >> cache_pkg::offset_w);
        if (v.op == op_fill) begin
            model[key] = data_in;
        end else if (v.exp[6] && v.op == op_wr) begin
            model[key] = (model[key] & ~mask_in) | (data_in & mask_in);
        end
        if (v.op == op_fill || v.exp[6]) begin
            exp_line = model[key];
        end else begin
            exp_line = '0;
        end
        exp_vo = v.exp[1];
        exp_rd = v.exp[0];
    endtask

    initial begin
        repeat (num_vectors * 20 + 100) @(posedge clk);
        $display("Timeout: the directed sequence did not complete");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h4f367675));
        rst       = 1'b1;
        valid_in  = 1'b0;
        r         = 1'b0;
        w         = 1'b0;
        from_bus  = 1'b0;
        pcd_in    = 1'b0;
        paddr_in  = '0;
        ptc_id_in = '0;
        data_in   = '0;
        mask_in   = '0;
        mshr_full = 1'b0;
        ser0_full = 1'b0;
        ser1_full = 1'b0;
        load_vectors();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_value("valid_out", valid_out, 1'b0);
        check_value("read", read, 1'b0);
        check_value("stall", stall, 1'b0);
        check_value("ex_clr", ex_clr, 1'b0);
        check_value("ex_wb", ex_wb, 1'b0);

        for (int i = 0; i < num_vectors; i++) begin
            drive_row(vectors[i]);
            #2;
            check_lookup(vectors[i]);
            predict_line(vectors[i]);
            @(negedge clk);
            check_value("valid_out", valid_out, exp_vo);
            check_value("read", read, exp_rd);
            check_value("cache_line", cache_line, exp_line);
        end

        valid_in = 1'b0;
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
